// ==== Bender.yml ====
package:
  name: keccak

sources:
  - keccak_pkg.sv
  - keccak_block_if.sv
  - keccak_padder.sv
  - keccak_round.sv
  - keccak_permutation.sv
  - keccak_digest.sv
  - keccak.sv
  - target: simulation
    files:
      - tb_clock_gen.sv
      - tb_keccak.sv

// ==== keccak.f ====
keccak_pkg.sv
keccak_block_if.sv
keccak_padder.sv
keccak_round.sv
keccak_permutation.sv
keccak_digest.sv
keccak.sv
tb_clock_gen.sv
tb_keccak.sv

// ==== keccak.sv ====
`timescale 1ns/1ps
`default_nettype none

module keccak (
    input  wire                               clk,
    input  wire                               reset,
    input  wire [31:0]                        in,
    input  wire                               in_ready,
    input  wire                               is_last,
    input  wire [1:0]                         byte_num,
    output wire                               buffer_full,  // user holds its word.
    output wire [keccak_pkg::digest_bits-1:0] out,
    output wire                               out_ready
);

    keccak_block_if blk_if ();  // padded block path.

    logic [keccak_pkg::state_bits-1:0] perm_state;
    logic                              perm_done;
    logic                              perm_busy;

    keccak_padder u_padder (
        .clk         (clk),
        .reset       (reset),
        .in          (in),
        .in_ready    (in_ready),
        .is_last     (is_last),
        .byte_num    (byte_num),
        .buffer_full (buffer_full),
        .blk         (blk_if.source)
    );

    keccak_permutation u_permutation (
        .clk       (clk),
        .reset     (reset),
        .blk       (blk_if.sink),
        .state_out (perm_state),
        .done      (perm_done),
        .busy      (perm_busy)
    );

    keccak_digest u_digest (
        .clk       (clk),
        .reset     (reset),
        .state_out (perm_state),
        .done      (perm_done),
        .busy      (perm_busy),
        .out       (out),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

// ==== keccak_block_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// padded block path, padder to permutation.
interface keccak_block_if;

    logic [keccak_pkg::rate_bits-1:0] block;    // little-endian lanes, lane 0 at bit 0.
    logic                             valid;    // block waiting.
    logic                             is_final; // last block of the message.
    logic                             ack;      // one-cycle take pulse.

    modport source (
        output block,
        output valid,
        output is_final,
        input  ack
    );

    modport sink (
        input  block,
        input  valid,
        input  is_final,
        output ack
    );

endinterface

`default_nettype wire

// ==== keccak_digest.sv ====
`timescale 1ns/1ps
`default_nettype none

module keccak_digest (
    input  wire                                clk,
    input  wire                                reset,
    input  wire [keccak_pkg::state_bits-1:0]   state_out,
    input  wire                                done,
    input  wire                                busy,
    output logic [keccak_pkg::digest_bits-1:0] out,
    output logic                               out_ready
);

    logic [keccak_pkg::digest_bits-1:0] digest_bytes;  // reordered lanes 0 to 7.

    // state byte k sits at bits 8k, digest byte k goes to the top.
    // same as swapping bytes in each lane and lanes in reverse.
    always_comb
    begin
        for (int k = 0; k < keccak_pkg::digest_bits / 8; k++)
            digest_bytes[keccak_pkg::digest_bits-8-8*k +: 8] = state_out[8*k +: 8];
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            out_ready <= 1'b0;
        else if (done)
            out_ready <= 1'b1;   // sticky until reset.
    end

    always_ff @(posedge clk)
    begin
        if (done && !out_ready)
            out <= digest_bytes;
    end

    assert property (@(posedge clk) disable iff (reset)
        out_ready |=> $stable(out) && out_ready);

    // one message per reset, permutation stays quiet after the digest.
    assert property (@(posedge clk) disable iff (reset)
        out_ready |-> !busy);

endmodule

`default_nettype wire

// ==== keccak_padder.sv ====
`timescale 1ns/1ps
`default_nettype none

module keccak_padder (
    input  wire            clk,
    input  wire            reset,
    input  wire [31:0]     in,          // first byte in bits 31:24.
    input  wire            in_ready,
    input  wire            is_last,
    input  wire [1:0]      byte_num,    // valid bytes of the last word.
    output logic           buffer_full,
    keccak_block_if.source blk
);

    // buffer holds the byte string, first byte at the top.
    logic [keccak_pkg::rate_bits-1:0] buf_q;
    logic [keccak_pkg::rate_bits-1:0] shifted;   // buffer with the new word appended.
    logic [keccak_pkg::rate_bits-1:0] padded;    // final block after alignment.
    logic [4:0]                       word_cnt_q;
    logic [4:0]                       words_left; // free word slots after this one.
    logic [31:0]                      tail_word;  // last word with the 0x01 byte.
    logic                             last_seen_q;
    logic                             final_q;
    logic                             accept;
    logic                             block_end;

    assign accept    = in_ready & ~buffer_full & ~last_seen_q;
    assign block_end = (word_cnt_q == 5'(keccak_pkg::words_per_block - 1));

    // the 0x01 byte lands right after the last valid byte.
    // with at most 3 valid bytes there is always room in this word.
    always_comb
    begin
        case (byte_num)
            2'd0:    tail_word = 32'h0100_0000;
            2'd1:    tail_word = {in[31:24], 24'h01_0000};
            2'd2:    tail_word = {in[31:16], 16'h0100};
            default: tail_word = {in[31:8], 8'h01};
        endcase
    end

    assign words_left = 5'(keccak_pkg::words_per_block - 1) - word_cnt_q;
    assign shifted    = {buf_q[keccak_pkg::rate_bits-33:0], is_last ? tail_word : in};

    // move word 0 to the top, zero fill, then 0x80 into byte 71.
    // on a full last slot this merges into 0x81.
    assign padded = (shifted << {words_left, 5'd0})
                  | {{(keccak_pkg::rate_bits-8){1'b0}}, 8'h80};

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            word_cnt_q  <= '0;
            buffer_full <= 1'b0;
            last_seen_q <= 1'b0;
            final_q     <= 1'b0;
        end
        else if (accept)
        begin
            if (is_last)
            begin
                word_cnt_q  <= '0;
                last_seen_q <= 1'b1;   // no more words this message.
                final_q     <= 1'b1;
                buffer_full <= 1'b1;
            end
            else if (block_end)
            begin
                word_cnt_q  <= '0;
                buffer_full <= 1'b1;   // 18th word, block complete.
            end
            else
            begin
                word_cnt_q <= word_cnt_q + 5'd1;
            end
        end
        else if (blk.ack)
        begin
            buffer_full <= 1'b0;       // free again the cycle after ack.
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
            buf_q <= is_last ? padded : shifted;
    end

    // byte k of the string goes to bits 8k, giving little-endian lanes.
    always_comb
    begin
        for (int k = 0; k < keccak_pkg::rate_bits / 8; k++)
            blk.block[8*k +: 8] = buf_q[keccak_pkg::rate_bits-8-8*k +: 8];
    end

    assign blk.valid    = buffer_full;
    assign blk.is_final = final_q;

    // a waiting block is never overwritten by a new word.
    assert property (@(posedge clk) disable iff (reset)
        blk.valid && !blk.ack |=> blk.valid && $stable(blk.block) && $stable(blk.is_final));

endmodule

`default_nettype wire

// ==== keccak_permutation.sv ====
`timescale 1ns/1ps
`default_nettype none

module keccak_permutation (
    input  wire                               clk,
    input  wire                               reset,
    keccak_block_if.sink                      blk,
    output logic [keccak_pkg::state_bits-1:0] state_out,
    output logic                              done,   // pulse after the final round.
    output logic                              busy
);

    keccak_pkg::perm_state_t          fsm_q;
    keccak_pkg::round_index_t         round_q;       // first round of this cycle.
    keccak_pkg::round_index_t         round_idx [keccak_pkg::rounds_per_cycle];
    logic [keccak_pkg::state_bits-1:0] state_q;
    logic [keccak_pkg::state_bits-1:0] chain [keccak_pkg::rounds_per_cycle+1];
    logic                              final_q;      // current block ends the message.
    logic                              last_step;

    assign chain[0] = state_q;

    // unrolled rounds, consecutive indices.
    for (genvar g = 0; g < keccak_pkg::rounds_per_cycle; g++)
    begin : g_round
        assign round_idx[g] = round_q + keccak_pkg::round_index_t'(g);

        keccak_round u_round (
            .state_in  (chain[g]),
            .round     (round_idx[g]),
            .state_out (chain[g+1])
        );
    end

    assign last_step = (round_q == keccak_pkg::round_index_t'(
                        keccak_pkg::num_rounds - keccak_pkg::rounds_per_cycle));

    assign blk.ack   = blk.valid && (fsm_q == keccak_pkg::perm_idle);  // take it at once.
    assign busy      = (fsm_q == keccak_pkg::perm_run);
    assign state_out = state_q;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            fsm_q   <= keccak_pkg::perm_idle;
            round_q <= '0;
            state_q <= '0;       // sponge starts from zero.
            final_q <= 1'b0;
            done    <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (fsm_q)
                keccak_pkg::perm_idle:
                begin
                    if (blk.ack)
                    begin
                        // absorb into the rate part.
                        state_q <= state_q ^ {{(keccak_pkg::state_bits -
                                   keccak_pkg::rate_bits){1'b0}}, blk.block};
                        final_q <= blk.is_final;
                        round_q <= '0;
                        fsm_q   <= keccak_pkg::perm_run;
                    end
                end
                keccak_pkg::perm_run:
                begin
                    state_q <= chain[keccak_pkg::rounds_per_cycle];
                    round_q <= round_q +
                               keccak_pkg::round_index_t'(keccak_pkg::rounds_per_cycle);
                    if (last_step)
                    begin
                        done  <= final_q;
                        fsm_q <= final_q ? keccak_pkg::perm_done : keccak_pkg::perm_idle;
                    end
                end
                default:
                begin
                    fsm_q <= keccak_pkg::perm_done;  // hold until reset.
                end
            endcase
        end
    end

    // a taken block leaves perm_run after num_rounds / rounds_per_cycle cycles.
    assert property (@(posedge clk) disable iff (reset)
        blk.ack |-> ##(keccak_pkg::num_rounds / keccak_pkg::rounds_per_cycle) busy ##1 !busy);

    assert property (@(posedge clk) disable iff (reset)
        done |=> !done);

endmodule

`default_nettype wire

// ==== keccak_pkg.sv ====
`default_nettype none

package keccak_pkg;

    // sponge geometry.
    localparam int rate_bits       = 576;             // 72 bytes per block.
    localparam int words_per_block = rate_bits / 32;  // input words per block.
    localparam int state_bits      = 1600;
    localparam int lane_bits       = 64;
    localparam int digest_bits     = 512;

    // permutation schedule.
    localparam int num_rounds       = 24;
    localparam int rounds_per_cycle = 2;   // must divide num_rounds.

    typedef logic [4:0] round_index_t;

    typedef enum logic [1:0] {
        perm_idle, // waiting for a block.
        perm_run,  // rounds in progress.
        perm_done  // final block permuted, state frozen.
    } perm_state_t;

    // iota constants, one per round.
    localparam logic [lane_bits-1:0] round_constants [num_rounds] = '{
        64'h0000_0000_0000_0001,
        64'h0000_0000_0000_8082,
        64'h8000_0000_0000_808a,
        64'h8000_0000_8000_8000,
        64'h0000_0000_0000_808b,
        64'h0000_0000_8000_0001,
        64'h8000_0000_8000_8081,
        64'h8000_0000_0000_8009,
        64'h0000_0000_0000_008a,
        64'h0000_0000_0000_0088,
        64'h0000_0000_8000_8009,
        64'h0000_0000_8000_000a,
        64'h0000_0000_8000_808b,
        64'h8000_0000_0000_008b,
        64'h8000_0000_0000_8089,
        64'h8000_0000_0000_8003,
        64'h8000_0000_0000_8002,
        64'h8000_0000_0000_0080,
        64'h0000_0000_0000_800a,
        64'h8000_0000_8000_000a,
        64'h8000_0000_8000_8081,
        64'h8000_0000_0000_8080,
        64'h0000_0000_8000_0001,
        64'h8000_0000_8000_8008
    };

    // rho offsets, indexed by x + 5*y.
    localparam int unsigned rotation_offsets [25] = '{
         0,  1, 62, 28, 27,   // y = 0.
        36, 44,  6, 55, 20,   // y = 1.
         3, 10, 43, 25, 39,   // y = 2.
        41, 45, 15, 21,  8,   // y = 3.
        18,  2, 61, 56, 14    // y = 4.
    };

endpackage

`default_nettype wire

// ==== keccak_round.sv ====
`timescale 1ns/1ps
`default_nettype none

// one keccak-f[1600] round, purely combinational.
module keccak_round (
    input  wire [keccak_pkg::state_bits-1:0] state_in,
    input  wire keccak_pkg::round_index_t    round,
    output logic [keccak_pkg::state_bits-1:0] state_out
);

    logic [keccak_pkg::lane_bits-1:0] a [25];  // lanes in, index x + 5*y.
    logic [keccak_pkg::lane_bits-1:0] b [25];  // after rho and pi.
    logic [keccak_pkg::lane_bits-1:0] e [25];  // after chi and iota.
    logic [keccak_pkg::lane_bits-1:0] c [5];   // column parity.
    logic [keccak_pkg::lane_bits-1:0] d [5];   // theta mix per column.

    function automatic logic [keccak_pkg::lane_bits-1:0] rotl(
        input logic [keccak_pkg::lane_bits-1:0] v,
        input int unsigned                      n
    );
        if (n == 0)
            rotl = v;
        else
            rotl = (v << n) | (v >> (keccak_pkg::lane_bits - n));
    endfunction

    always_comb
    begin
        for (int i = 0; i < 25; i++)
            a[i] = state_in[keccak_pkg::lane_bits*i +: keccak_pkg::lane_bits];

        // theta.
        for (int x = 0; x < 5; x++)
            c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20];
        for (int x = 0; x < 5; x++)
            d[x] = c[(x+4)%5] ^ rotl(c[(x+1)%5], 1);

        // rho and pi, lane (x,y) moves to (y, 2x+3y).
        for (int x = 0; x < 5; x++)
        begin
            for (int y = 0; y < 5; y++)
                b[y + 5*((2*x + 3*y) % 5)] =
                    rotl(a[x + 5*y] ^ d[x], keccak_pkg::rotation_offsets[x + 5*y]);
        end

        // chi, row-wise nonlinear step.
        for (int y = 0; y < 5; y++)
        begin
            for (int x = 0; x < 5; x++)
                e[x + 5*y] = b[x + 5*y] ^ (~b[(x+1)%5 + 5*y] & b[(x+2)%5 + 5*y]);
        end

        e[0] = e[0] ^ keccak_pkg::round_constants[round];  // iota.

        for (int i = 0; i < 25; i++)
            state_out[keccak_pkg::lane_bits*i +: keccak_pkg::lane_bits] = e[i];
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    input  wire  reset_req,  // request another reset sequence.
    output logic clk,
    output logic reset
);

    localparam int half_period  = 5;  // 10 ns clock.
    localparam int reset_cycles = 8;

    initial
    begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // power-on reset, then one more sequence per request.
    initial
    begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        #1 reset = 1'b0;
        forever
        begin
            @(posedge reset_req);
            reset = 1'b1;
            repeat (reset_cycles) @(posedge clk);
            #1 reset = 1'b0;  // released off the edge.
        end
    end

endmodule

`default_nettype wire

// ==== tb_keccak.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_keccak;

    // about 450 cycles of tests, four times that as the limit.
    localparam int max_cycles = 2000;

    localparam logic [keccak_pkg::digest_bits-1:0] kat_empty = {
        128'h0eab42de_4c3ceb92_35fc91ac_ffe746b2, 128'h9c29a8c3_66b7c60e_4e67c466_f36a4304,
        128'hc00fa9ca_f9d87976_ba469bcb_e06713b4, 128'h35f091ef_2769fb16_0cdab33d_3670680e
    };
    localparam logic [keccak_pkg::digest_bits-1:0] kat_abc = {
        128'h18587dc2_ea106b9a_1563e32b_3312421c, 128'ha164c7f1_f07bc922_a9c83d77_cea3a1e5,
        128'hd0c69910_73902537_2dc14ac9_64262937, 128'h9540c17e_2a65b19d_77aa511a_9d00bb96
    };

    logic                               clk;
    logic                               reset;
    logic                               reset_req;
    logic [31:0]                        in_word;
    logic                               in_ready;
    logic                               is_last;
    logic [1:0]                         byte_num;
    logic                               buffer_full;
    logic [keccak_pkg::digest_bits-1:0] out;
    logic                               out_ready;

    int          seed;
    int          cycle_count;
    int          digest_errors;
    int          level_errors;
    logic [7:0]  msg [0:255];     // message bytes, first byte at 0.
    int          msg_len;
    logic [63:0] lanes [0:25-1];  // reference sponge state, index x + 5*y.
    logic [63:0] rc_tab [0:23];
    int          rho_tab [0:24];

    tb_clock_gen u_clock_gen (
        .reset_req (reset_req),
        .clk       (clk),
        .reset     (reset)
    );

    keccak u_dut (
        .clk         (clk),
        .reset       (reset),
        .in          (in_word),
        .in_ready    (in_ready),
        .is_last     (is_last),
        .byte_num    (byte_num),
        .buffer_full (buffer_full),
        .out         (out),
        .out_ready   (out_ready)
    );

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= max_cycles)
        begin
            $display("timeout: the DUT did not finish within %0d cycles", max_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic check_digest(input logic [keccak_pkg::digest_bits-1:0] expected,
                                input logic [keccak_pkg::digest_bits-1:0] actual,
                                input string what);
        if (actual !== expected)
        begin
            digest_errors++;
            $display("CHECK FAILED at %0t: %s, expected %h, got %h",
                     $time, what, expected, actual);
        end
    endtask

    task automatic check_level(input logic expected, input logic actual, input string what);
        if (actual !== expected)
        begin
            level_errors++;
            $display("CHECK FAILED at %0t: %s, expected %b, got %b",
                     $time, what, expected, actual);
        end
    endtask

    function automatic logic [63:0] rotate_left(input logic [63:0] v, input int n);
        logic [127:0] wide;
        wide = {v, v} << n;
        return wide[127:64];
    endfunction

    // iota constants from the rc lfsr, rho offsets from the (x,y) walk.
    task automatic build_tables();
        logic [7:0] lfsr;
        int         x;
        int         y;
        int         tmp;
        lfsr = 8'h01;
        for (int r = 0; r < 24; r++)
        begin
            rc_tab[r] = '0;
            for (int j = 0; j < 7; j++)
            begin
                if (lfsr[0])
                    rc_tab[r][(1 << j) - 1] = 1'b1;
                lfsr = lfsr[7] ? ((lfsr << 1) ^ 8'h71) : (lfsr << 1);
            end
        end
        x = 1;
        y = 0;
        rho_tab[0] = 0;
        for (int t = 0; t < 24; t++)
        begin
            rho_tab[x + 5*y] = ((t + 1) * (t + 2) / 2) % 64;
            tmp = y;
            y = (2*x + 3*y) % 5;
            x = tmp;
        end
    endtask

    task automatic permute();
        logic [63:0] col [0:4];
        logic [63:0] tmp [0:24];
        logic [63:0] mix;
        for (int r = 0; r < 24; r++)
        begin
            for (int x = 0; x < 5; x++)
                col[x] = lanes[x] ^ lanes[x+5] ^ lanes[x+10] ^ lanes[x+15] ^ lanes[x+20];
            for (int x = 0; x < 5; x++)
            begin
                mix = col[(x+4)%5] ^ rotate_left(col[(x+1)%5], 1);
                for (int y = 0; y < 5; y++)
                    lanes[x + 5*y] ^= mix;
            end
            for (int i = 0; i < 25; i++)   // rho and pi together.
                tmp[i/5 + 5*((2*(i%5) + 3*(i/5)) % 5)] = rotate_left(lanes[i], rho_tab[i]);
            for (int i = 0; i < 25; i++)
                lanes[i] = tmp[i] ^ (~tmp[5*(i/5) + (i+1)%5] & tmp[5*(i/5) + (i+2)%5]);
            lanes[0] ^= rc_tab[r];
        end
    endtask

    // sponge over msg with pad10*1, 72-byte rate.
    task automatic reference_digest(output logic [keccak_pkg::digest_bits-1:0] d);
        logic [7:0] pb;
        int         nblk;
        int         p;
        nblk = msg_len / 72 + 1;
        for (int i = 0; i < 25; i++)
            lanes[i] = '0;
        for (int b = 0; b < nblk; b++)
        begin
            for (int i = 0; i < 72; i++)
            begin
                p  = 72*b + i;
                pb = (p < msg_len) ? msg[p] : 8'h00;
                if (p == msg_len)
                    pb |= 8'h01;
                if (b == nblk - 1 && i == 71)
                    pb |= 8'h80;   // merges to 0x81 when needed.
                lanes[i/8][8*(i%8) +: 8] ^= pb;
            end
            permute();
        end
        for (int k = 0; k < 64; k++)
            d[511 - 8*k -: 8] = lanes[k/8][8*(k%8) +: 8];
    endtask

    task automatic fill_random(input int len);
        int r;
        msg_len = len;
        for (int i = 0; i < len; i++)
        begin
            r      = $random(seed);
            msg[i] = r[7:0];
        end
    endtask

    task automatic apply_reset();
        reset_req = 1'b1;
        @(negedge reset);      // falls 1 ns after an edge.
        reset_req = 1'b0;
    endtask

    // random gap, then hold the word until an edge with buffer_full low.
    task automatic send_word(input logic [31:0] word, input logic last, input logic [1:0] nb);
        int   gap;
        logic full_at_edge;
        gap = {$random(seed)} % 3;
        repeat (gap)
        begin
            @(posedge clk);
            #1;
        end
        if (!last)
            check_level(1'b0, out_ready, "out_ready before the last word");
        in_word  = word;
        in_ready = 1'b1;
        is_last  = last;
        byte_num = nb;
        do
        begin
            full_at_edge = buffer_full;
            @(posedge clk);
            #1;
        end
        while (full_at_edge);
        in_ready = 1'b0;
        is_last  = 1'b0;
    endtask

    task automatic hash_message(input logic [keccak_pkg::digest_bits-1:0] expected,
                                input string name, input int hold_cycles);
        logic [31:0] word;
        int          nfull;
        int          rem;
        apply_reset();
        check_level(1'b0, out_ready, "out_ready after reset");
        check_level(1'b0, buffer_full, "buffer_full after reset");
        nfull = msg_len / 4;
        rem   = msg_len % 4;
        for (int w = 0; w < nfull; w++)
            send_word({msg[4*w], msg[4*w+1], msg[4*w+2], msg[4*w+3]}, 1'b0, 2'd0);
        word = $random(seed);   // junk in the unused bytes.
        for (int b = 0; b < rem; b++)
            word[31 - 8*b -: 8] = msg[4*nfull + b];
        send_word(word, 1'b1, rem[1:0]);
        while (out_ready !== 1'b1)
        begin
            @(posedge clk);
            #1;
        end
        check_digest(expected, out, name);
        repeat (hold_cycles)
        begin
            @(posedge clk);
            #1;
            check_level(1'b1, out_ready, "out_ready held");
            check_digest(expected, out, "out held");
        end
    endtask

    task automatic test_idle_after_reset();
        check_level(1'b0, out_ready, "out_ready after power-on reset");
        check_level(1'b0, buffer_full, "buffer_full after power-on reset");
        repeat (5)
        begin
            @(posedge clk);
            #1;
            check_level(1'b0, out_ready, "out_ready with no input");
        end
    endtask

    task automatic test_empty();
        logic [keccak_pkg::digest_bits-1:0] model;
        msg_len = 0;
        reference_digest(model);
        check_digest(kat_empty, model, "reference model, empty string");
        hash_message(kat_empty, "empty message", 0);
    endtask

    task automatic test_short_tails();
        logic [keccak_pkg::digest_bits-1:0] model;
        for (int len = 1; len <= 2; len++)
        begin
            fill_random(len);
            reference_digest(model);
            hash_message(model, "short message", 0);
        end
        msg_len = 3;
        msg[0]  = 8'h61;   // "abc".
        msg[1]  = 8'h62;
        msg[2]  = 8'h63;
        reference_digest(model);
        check_digest(kat_abc, model, "reference model, abc");
        hash_message(kat_abc, "message abc", 0);
    endtask

    task automatic test_long_messages();
        logic [keccak_pkg::digest_bits-1:0] model;
        fill_random(71);   // padding fills the very last byte.
        reference_digest(model);
        hash_message(model, "71-byte message", 0);
        fill_random(200);  // three blocks.
        reference_digest(model);
        hash_message(model, "200-byte message", 50);
    endtask

    initial
    begin
        seed          = 32'h1bc3_94c8;
        cycle_count   = 0;
        digest_errors = 0;
        level_errors  = 0;
        reset_req     = 1'b0;
        in_word       = '0;
        in_ready      = 1'b0;
        is_last       = 1'b0;
        byte_num      = 2'd0;
        build_tables();
        @(negedge reset);
        test_idle_after_reset();
        test_empty();
        test_short_tails();
        test_long_messages();
        $display("errors: %0d digest, %0d level", digest_errors, level_errors);
        if (digest_errors + level_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire
